// File: hazardCtrl.f
hw/pipeCtrlPkg.sv
hw/stageTracker.sv
hw/hazardDetect.sv
hw/mulDivTimer.sv
hw/excLevelReg.sv
hw/stallArbiter.sv
hw/hazardCtrl.sv
sim/hazardCtrlTb.sv

// File: hw/excLevelReg.sv
`timescale 1ns/1ps

module excLevelReg (
    input  logic clk,
    input  logic rstN,
    input  logic excReq,
    input  logic eretAccept,
    output logic exl,
    output logic flush
);

    // exl set on entry, dropped by eret
    // flush pulses for the cycle after either event
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exl   <= 1'b0;
            flush <= 1'b0;
        end else begin
            if (excReq) begin
                // exception has priority over a same-cycle eret
                exl   <= 1'b1;
                flush <= 1'b1;
            end else if (eretAccept) begin
                exl   <= 1'b0;
                flush <= 1'b1;
            end else begin
                flush <= 1'b0;
            end
        end
    end

endmodule

// File: hw/hazardCtrl.sv
`timescale 1ns/1ps

module hazardCtrl
    import pipeCtrlPkg::*;
(
    input  logic         clk,
    input  logic         rstN,
    input  logic         instrValid,
    input  decodedInstrT instr,
    input  logic         busyI,
    input  logic         busyD,
    input  logic         excReq,
    output logic         instrReady,
    output ctrlVecT      ctrl,
    output logic         exl,
    output logic         busyMd
);

    // in-flight write records checked at D
    stageRecT recE;
    stageRecT recM;
    // hazard and arbiter handshake
    logic waitReg;
    logic waitMd;
    logic flush;
    logic accept;
    // class-qualified accepts
    logic mdStart;
    logic eretAccept;

    assign mdStart    = accept && (instr.instrClass == MD);
    assign eretAccept = accept && (instr.instrClass == ERET);

    // W record kept for pipeline alignment only
    stageTracker tracker (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .accept(accept), .instr(instr),
        .recE(recE), .recM(recM), .recW()
    );

    hazardDetect detect (
        .instr(instr), .instrValid(instrValid), .recE(recE), .recM(recM),
        .busyMd(busyMd), .waitReg(waitReg), .waitMd(waitMd)
    );

    mulDivTimer mdTimer (
        .clk(clk), .rstN(rstN), .start(mdStart), .busyMd(busyMd)
    );

    excLevelReg exlReg (
        .clk(clk), .rstN(rstN), .excReq(excReq), .eretAccept(eretAccept),
        .exl(exl), .flush(flush)
    );

    stallArbiter arbiter (
        .flush(flush), .busyI(busyI), .busyD(busyD), .waitReg(waitReg),
        .waitMd(waitMd), .instrValid(instrValid), .ctrl(ctrl),
        .instrReady(instrReady), .accept(accept)
    );

endmodule

// File: hw/hazardDetect.sv
`timescale 1ns/1ps

module hazardDetect
    import pipeCtrlPkg::*;
(
    input  decodedInstrT instr,
    input  logic         instrValid,
    input  stageRecT     recE,
    input  stageRecT     recM,
    input  logic         busyMd,
    output logic         waitReg,
    output logic         waitMd
);

    // per-operand stall requests
    logic waitRs;
    logic waitRt;
    // instruction needs the multiply-divide unit
    logic usesMd;

    // record writes addr and will not be ready in time
    function automatic logic recHit(
        input stageRecT rec,
        input regAddrT  addr,
        input timeT     tuse
    );
        return rec.valid && rec.regWEn && (rec.regWAddr == addr) && (rec.tnew > tuse);
    endfunction

    always_comb begin
        // r0 reads never wait
        waitRs = instr.useRs && (instr.rs != '0)
                 && (recHit(recE, instr.rs, instr.tuseRs)
                     || recHit(recM, instr.rs, instr.tuseRs));
        waitRt = instr.useRt && (instr.rt != '0)
                 && (recHit(recE, instr.rt, instr.tuseRt)
                     || recHit(recM, instr.rt, instr.tuseRt));

        // W is past the forwarding point, not checked
        waitReg = instrValid && (waitRs || waitRt);

        // both starting a new op and reading HI/LO must wait
        usesMd = (instr.instrClass == MD) || (instr.instrClass == MFMD);
        waitMd = instrValid && busyMd && usesMd;
    end

endmodule

// File: hw/mulDivTimer.sv
`timescale 1ns/1ps

module mulDivTimer
    import pipeCtrlPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic start,
    output logic busyMd
);

    // cycles left on the current operation
    logic [MD_CNT_W-1:0] remain;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            remain <= '0;
        end else if (start) begin
            // reload, busy from the next cycle
            remain <= MD_CNT_W'(MD_LATENCY);
        end else if (remain != '0) begin
            remain <= remain - 1'b1;
        end
    end

    // high for exactly MD_LATENCY cycles after start
    assign busyMd = (remain != '0);

endmodule

// File: hw/pipeCtrlPkg.sv
package pipeCtrlPkg;

    // register number, r0 is hardwired zero
    typedef logic [4:0] regAddrT;

    // tnew / tuse in cycles
    typedef logic [1:0] timeT;

    // instruction classes seen at D
    typedef enum logic [2:0] {
        ALU,
        LOAD,
        STORE,
        MD,
        MFMD,
        ERET
    } instrClassT;

    // decoded instruction waiting in D
    typedef struct packed {
        instrClassT instrClass;
        logic       useRs;
        logic       useRt;
        regAddrT    rs;
        regAddrT    rt;
        timeT       tuseRs;
        timeT       tuseRt;
        logic       regWEn;
        regAddrT    regWAddr;
        // cycles until result ready, counted from E
        timeT       tnew;
    } decodedInstrT;

    // one in-flight register write
    typedef struct packed {
        logic    valid;
        logic    regWEn;
        regAddrT regWAddr;
        timeT    tnew;
    } stageRecT;

    // enables, stalls and clears for the core
    typedef struct packed {
        logic enPc;
        logic enMd;
        logic enD;
        logic enGrf;
        logic stallD;
        logic stallE;
        logic stallM;
        logic stallW;
        logic clearD;
        logic clearE;
        logic clearM;
        logic clearW;
    } ctrlVecT;

    // multiply-divide busy time after start
    localparam int MD_LATENCY = 5;
    localparam int MD_CNT_W   = $clog2(MD_LATENCY + 1);

    // control vectors, highest priority first
    localparam ctrlVecT CTRL_FLUSH   = 12'b1001_0000_1111;
    localparam ctrlVecT CTRL_MEMWAIT = 12'b0111_1111_0000;
    localparam ctrlVecT CTRL_HAZARD  = 12'b0111_1000_0100;
    localparam ctrlVecT CTRL_RUN     = 12'b1111_0000_0000;

endpackage

// File: hw/stageTracker.sv
`timescale 1ns/1ps

module stageTracker
    import pipeCtrlPkg::*;
(
    input  logic         clk,
    input  logic         rstN,
    input  ctrlVecT      ctrl,
    input  logic         accept,
    input  decodedInstrT instr,
    output stageRecT     recE,
    output stageRecT     recM,
    output stageRecT     recW
);

    // empty slot, never matches a reader
    localparam stageRecT BUBBLE = '0;

    // record built from the D-stage instruction
    stageRecT recD;

    // one stage of aging, tnew floors at zero
    function automatic stageRecT ageRec(input stageRecT rec);
        stageRecT aged;
        aged = rec;
        if (aged.tnew != '0) begin
            aged.tnew = aged.tnew - 1'b1;
        end
        return aged;
    endfunction

    // bubble unless the handshake completes this cycle
    always_comb begin
        recD = BUBBLE;
        if (accept) begin
            recD.valid    = 1'b1;
            recD.regWEn   = instr.regWEn;
            recD.regWAddr = instr.regWAddr;
            recD.tnew     = instr.tnew;
        end
    end

    // clear beats stall beats advance, per stage
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            recE <= BUBBLE;
            recM <= BUBBLE;
            recW <= BUBBLE;
        end else begin
            // E enters with the decoded tnew, no aging yet
            if (ctrl.clearE) begin
                recE <= BUBBLE;
            end else if (!ctrl.stallE) begin
                recE <= recD;
            end
            // E to M
            if (ctrl.clearM) begin
                recM <= BUBBLE;
            end else if (!ctrl.stallM) begin
                recM <= ageRec(recE);
            end
            // M to W
            if (ctrl.clearW) begin
                recW <= BUBBLE;
            end else if (!ctrl.stallW) begin
                recW <= ageRec(recM);
            end
        end
    end

endmodule

// File: hw/stallArbiter.sv
`timescale 1ns/1ps

module stallArbiter
    import pipeCtrlPkg::*;
(
    input  logic    flush,
    input  logic    busyI,
    input  logic    busyD,
    input  logic    waitReg,
    input  logic    waitMd,
    input  logic    instrValid,
    output ctrlVecT ctrl,
    output logic    instrReady,
    output logic    accept
);

    // fetch stall and D-stage waits share one response
    logic holdD;

    always_comb begin
        holdD = waitMd || waitReg || busyI;

        // flush > data memory wait > D hold > run
        if (flush) begin
            ctrl = CTRL_FLUSH;
        end else if (busyD) begin
            // whole pipe frozen, hazards resolve later
            ctrl = CTRL_MEMWAIT;
        end else if (holdD) begin
            // keep D, bubble into E
            ctrl = CTRL_HAZARD;
        end else begin
            ctrl = CTRL_RUN;
        end

        // D only moves on in the run state
        instrReady = (ctrl == CTRL_RUN);
        accept     = instrReady && instrValid;
    end

endmodule

// File: runSim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module hazardCtrlTb -f hazardCtrl.f -o hazardCtrlSim \
    || { echo "build failed"; exit 1; }
./obj_dir/hazardCtrlSim > sim.log 2>&1 || echo "Some tests failed" >> sim.log
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0

// File: sim/hazardCtrlTb.sv
`timescale 1ns/1ps

module hazardCtrlTb
    import pipeCtrlPkg::*;
();

    // summed test lengths in cycles with the random mix included
    localparam int TEST_CYCLES = 470;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES + 50;
    localparam int READY_WAIT  = 40;

    // expected outputs of one cycle
    typedef struct packed {
        ctrlVecT ctrl;
        logic    ready;
        logic    exl;
    } expectT;

    logic         clk = 1'b0;
    logic         rstN;
    logic         instrValid;
    decodedInstrT instr;
    logic         busyI;
    logic         busyD;
    logic         excReq;
    logic         instrReady;
    ctrlVecT      ctrl;
    logic         exl;
    logic         busyMd;

    // reference model state
    stageRecT mE = '0;
    stageRecT mM = '0;
    int       mdLeft = 0;
    logic     mExl = 1'b0;
    logic     mFlush = 1'b0;
    logic     lastAccept = 1'b0;
    expectT   exp;

    logic [31:0] lcgState = 32'h79f109db;
    logic [31:0] rnd;
    int          errorCount = 0;
    int          errorsBefore = 0;
    int          checkCount = 0;
    int          testNum = 0;
    int          cycleCount = 0;
    int          waits;

    hazardCtrl dut (
        .clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
        .busyI(busyI), .busyD(busyD), .excReq(excReq), .instrReady(instrReady),
        .ctrl(ctrl), .exl(exl), .busyMd(busyMd)
    );

    always #50 clk = ~clk;

    function logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // write record that is still too young for the reader
    function automatic logic writesLate(input stageRecT r, input regAddrT a, input timeT tuse);
        return r.valid && r.regWEn && (a != 5'd0) && (r.regWAddr == a) && (r.tnew > tuse);
    endfunction

    function automatic stageRecT aged(input stageRecT r);
        stageRecT o;
        o = r;
        if (o.tnew != 2'd0) begin
            o.tnew = o.tnew - 2'd1;
        end
        return o;
    endfunction

    // reference priority is flush, memory wait, D hold and run
    function automatic expectT expectOut(input decodedInstrT d, input logic v);
        expectT e;
        logic   regWait;
        logic   mdWait;
        regWait = v && ((d.useRs && (writesLate(mE, d.rs, d.tuseRs)
                                     || writesLate(mM, d.rs, d.tuseRs)))
                        || (d.useRt && (writesLate(mE, d.rt, d.tuseRt)
                                        || writesLate(mM, d.rt, d.tuseRt))));
        mdWait = v && (mdLeft != 0) && ((d.instrClass == MD) || (d.instrClass == MFMD));
        if (mFlush) begin
            e.ctrl = CTRL_FLUSH;
        end else if (busyD) begin
            e.ctrl = CTRL_MEMWAIT;
        end else if (regWait || mdWait || busyI) begin
            e.ctrl = CTRL_HAZARD;
        end else begin
            e.ctrl = CTRL_RUN;
        end
        e.ready = (e.ctrl == CTRL_RUN);
        e.exl = mExl;
        return e;
    endfunction

    function automatic decodedInstrT mkInstr(input instrClassT c, input regAddrT src,
                                             input timeT tuse, input regAddrT dst,
                                             input timeT tnew);
        decodedInstrT d;
        d = '0;
        d.instrClass = c;
        d.useRs = 1'b1;
        d.rs = src;
        d.tuseRs = tuse;
        d.regWEn = (c == ALU) || (c == LOAD) || (c == MFMD);
        d.regWAddr = dst;
        d.tnew = tnew;
        return d;
    endfunction

    // small register range so hazards come up often
    function automatic decodedInstrT randInstr();
        decodedInstrT d;
        logic [31:0]  v;
        v = nextRand();
        d.instrClass = instrClassT'(v[2:0] % 3'd6);
        d.useRs = v[3];
        d.useRt = v[4];
        d.rs = {2'b00, v[7:5]};
        d.rt = {2'b00, v[10:8]};
        d.tuseRs = v[12:11];
        d.tuseRt = v[14:13];
        d.regWEn = (d.instrClass == ALU) || (d.instrClass == LOAD) || (d.instrClass == MFMD);
        d.regWAddr = {2'b00, v[17:15]};
        d.tnew = (d.instrClass == LOAD) ? 2'd2 : (d.regWEn ? 2'd1 : 2'd0);
        return d;
    endfunction

    task automatic checkThat(input logic ok, input string what);
        checkCount++;
        assert (ok) else begin
            errorCount++;
            $display("ERROR %0t: %s", $time, what);
        end
    endtask

    // present at a falling edge and hold until accepted
    task automatic sendInstr(input decodedInstrT d, output int n);
        n = 0;
        instr = d;
        instrValid = 1'b1;
        forever begin
            @(posedge clk);
            if (instrReady) begin
                break;
            end
            n++;
            if (n > READY_WAIT) begin
                errorCount++;
                $display("instrReady never came back for a pending instruction");
                break;
            end
        end
        @(negedge clk);
        instrValid = 1'b0;
    endtask

    task automatic finishTest(input string name);
        testNum++;
        $display("test %0d %s: %0d errors", testNum, name, errorCount - errorsBefore);
        errorsBefore = errorCount;
    endtask

    // compare then step the model on pre-edge values
    always @(posedge clk) begin
        if (!rstN) begin
            mE = '0;
            mM = '0;
            mdLeft = 0;
            mExl = 1'b0;
            mFlush = 1'b0;
        end else begin
            exp = expectOut(instr, instrValid);
            checkCount++;
            assert ({ctrl, instrReady, exl, busyMd} == {exp, mdLeft != 0}) else begin
                errorCount++;
                $display("ERROR %0t: ctrl %h ready %b exl %b busyMd %b, expected %h %b %b %b",
                         $time, ctrl, instrReady, exl, busyMd,
                         exp.ctrl, exp.ready, exp.exl, mdLeft != 0);
            end
            lastAccept = exp.ready && instrValid;
            if (exp.ctrl == CTRL_FLUSH) begin
                mE = '0;
                mM = '0;
            end else if (exp.ctrl != CTRL_MEMWAIT) begin
                mM = aged(mE);
                mE = '0;
                if (lastAccept) begin
                    mE = {1'b1, instr.regWEn, instr.regWAddr, instr.tnew};
                end
            end
            if (lastAccept && (instr.instrClass == MD)) begin
                mdLeft = MD_LATENCY;
            end else if (mdLeft != 0) begin
                mdLeft--;
            end
            mFlush = excReq || (lastAccept && (instr.instrClass == ERET));
            if (excReq) begin
                mExl = 1'b1;
            end else if (lastAccept && (instr.instrClass == ERET)) begin
                mExl = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without reaching the end", cycleCount);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        rstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        busyI = 1'b0;
        busyD = 1'b0;
        excReq = 1'b0;
        repeat (3) @(negedge clk);
        rstN = 1'b1;

        @(posedge clk);
        checkThat(ctrl == CTRL_RUN && instrReady && !exl && !busyMd, "state after reset");
        @(negedge clk);
        finishTest("reset");

        // reader of r5 with tuse 0 waits out the load in E and M
        sendInstr(mkInstr(LOAD, 5'd0, 2'd0, 5'd5, 2'd2), waits);
        sendInstr(mkInstr(ALU, 5'd5, 2'd0, 5'd6, 2'd1), waits);
        checkThat(waits == 2, "load-use stall length");
        repeat (3) @(negedge clk);
        sendInstr(mkInstr(LOAD, 5'd0, 2'd0, 5'd0, 2'd2), waits);
        sendInstr(mkInstr(ALU, 5'd0, 2'd0, 5'd6, 2'd1), waits);
        checkThat(waits == 0, "r0 reader stalled");
        repeat (3) @(negedge clk);
        finishTest("load-use");

        sendInstr(mkInstr(MD, 5'd0, 2'd0, 5'd0, 2'd0), waits);
        waits = 0;
        @(posedge clk);
        while (busyMd && waits < READY_WAIT) begin
            waits++;
            @(posedge clk);
        end
        checkThat(waits == MD_LATENCY, "busyMd length");
        @(negedge clk);
        sendInstr(mkInstr(MD, 5'd0, 2'd0, 5'd0, 2'd0), waits);
        sendInstr(mkInstr(MFMD, 5'd0, 2'd0, 5'd7, 2'd1), waits);
        checkThat(waits == MD_LATENCY, "MFMD hold length");
        sendInstr(mkInstr(MD, 5'd0, 2'd0, 5'd0, 2'd0), waits);
        sendInstr(mkInstr(ALU, 5'd0, 2'd0, 5'd3, 2'd1), waits);
        checkThat(waits == 0, "ALU held while MD busy");
        repeat (6) @(negedge clk);
        finishTest("multiply-divide");

        // memory wait outranks a pending hazard and busyI
        sendInstr(mkInstr(LOAD, 5'd0, 2'd0, 5'd5, 2'd2), waits);
        instr = mkInstr(ALU, 5'd5, 2'd0, 5'd6, 2'd1);
        instrValid = 1'b1;
        busyD = 1'b1;
        busyI = 1'b1;
        @(posedge clk);
        checkThat(ctrl == CTRL_MEMWAIT, "busyD priority");
        @(negedge clk);
        busyD = 1'b0;
        instrValid = 1'b0;
        @(posedge clk);
        checkThat(ctrl == CTRL_HAZARD, "busyI alone");
        @(negedge clk);
        busyI = 1'b0;
        repeat (4) @(negedge clk);
        finishTest("busy priority");

        // exception raised in the cycle the load is accepted
        excReq = 1'b1;
        sendInstr(mkInstr(LOAD, 5'd0, 2'd0, 5'd5, 2'd2), waits);
        excReq = 1'b0;
        @(posedge clk);
        checkThat(ctrl == CTRL_FLUSH && exl, "flush on exception");
        @(negedge clk);
        // flushed load would still sit in M and no longer blocks its reader
        sendInstr(mkInstr(ALU, 5'd5, 2'd0, 5'd6, 2'd1), waits);
        checkThat(waits == 0, "hazard kept across flush");
        sendInstr(mkInstr(ERET, 5'd0, 2'd0, 5'd0, 2'd0), waits);
        @(posedge clk);
        checkThat(ctrl == CTRL_FLUSH && !exl, "flush on eret");
        @(negedge clk);
        repeat (2) @(negedge clk);
        finishTest("exception");

        // instr held while valid and not ready
        for (int i = 0; i < 400; i++) begin
            rnd = nextRand();
            if (!instrValid || lastAccept) begin
                instrValid = rnd[0] | rnd[1];
                instr = randInstr();
            end
            busyI = (rnd[4:2] == 3'd0);
            busyD = (rnd[7:5] == 3'd0);
            excReq = (rnd[12:8] == 5'd0);
            @(negedge clk);
        end
        instrValid = 1'b0;
        busyI = 1'b0;
        busyD = 1'b0;
        excReq = 1'b0;
        finishTest("random mix");

        $display("%0d tests, %0d checks, %0d errors", testNum, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
